// ==== include/regalu_defs.svh ====
`ifndef REGALU_DEFS_SVH
`define REGALU_DEFS_SVH

// ********************************************************************
// datapath sizing
// ********************************************************************

`define REGALU_DATA_WIDTH 8   // operand and register width.
`define REGALU_REG_COUNT  8   // registers in the file.
`define REGALU_ADDR_WIDTH 3   // enough to index every register.

`endif

// ==== rtl/regalu_pkg.sv ====
`default_nettype none

`include "regalu_defs.svh"

package regalu_pkg;

    // ********************************************************************
    // datapath types
    // ********************************************************************

    typedef logic [`REGALU_DATA_WIDTH-1:0] data_t;
    typedef logic [`REGALU_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        op_load = 2'd0,  // dest := imm.
        op_add  = 2'd1,  // dest := src_a + src_b.
        op_sub  = 2'd2,  // dest := src_a - src_b.
        op_read = 2'd3   // result := src_a without a write.
    } op_t;

    // ********************************************************************
    // sequencer states
    // ********************************************************************

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_read = 2'd1,
        st_exec = 2'd2,
        st_ack  = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/regfile_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;

    logic                  rd0_en;
    regalu_pkg::reg_addr_t rd0_addr;
    regalu_pkg::data_t     rd0_data;   // registered and valid one cycle after rd0_en.
    logic                  rd1_en;
    regalu_pkg::reg_addr_t rd1_addr;
    regalu_pkg::data_t     rd1_data;
    logic                  wr_en;
    regalu_pkg::reg_addr_t wr_addr;
    regalu_pkg::data_t     wr_data;

    modport seq (
        output rd0_en, rd0_addr,
        output rd1_en, rd1_addr,
        output wr_en, wr_addr, wr_data,
        input  rd0_data, rd1_data
    );

    modport regs (
        input  rd0_en, rd0_addr,
        input  rd1_en, rd1_addr,
        input  wr_en, wr_addr, wr_data,
        output rd0_data, rd1_data
    );

    // operand side only.
    modport alu (
        input  rd0_data, rd1_data
    );

endinterface

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regalu_defs.svh"

module alu (
    input  regalu_pkg::data_t a,
    input  regalu_pkg::data_t b,
    input  logic              subtract,
    output regalu_pkg::data_t sum,
    output logic              cout
);

    // ********************************************************************
    // elaboration check
    // ********************************************************************

    if ($bits(regalu_pkg::data_t) != `REGALU_DATA_WIDTH) begin : g_width_check
        $error("alu: data_t width does not match REGALU_DATA_WIDTH");
    end

    // ********************************************************************
    // adder / subtractor
    // ********************************************************************

    regalu_pkg::data_t           b_eff;
    logic [`REGALU_DATA_WIDTH:0] full_sum;

    // two's complement subtract is a + ~b + 1.
    assign b_eff = subtract ? ~b : b;

    always_comb begin
        full_sum = {1'b0, a}
                 + {1'b0, b_eff}
                 + {{`REGALU_DATA_WIDTH{1'b0}}, subtract};  // carry in.
    end

    // for subtract, cout high means no borrow.
    assign sum  = full_sum[`REGALU_DATA_WIDTH-1:0];
    assign cout = full_sum[`REGALU_DATA_WIDTH];

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regalu_defs.svh"

module register_file (
    input  logic   clk,
    input  logic   reset,
    regfile_if.regs regs
);

    regalu_pkg::data_t mem [`REGALU_REG_COUNT];

    // ********************************************************************
    // write port
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (regs.wr_en) begin
            mem[regs.wr_addr] <= regs.wr_data;
        end
    end

    // ********************************************************************
    // read ports
    // ********************************************************************

    // same-cycle write to the read address returns the old value.
    always_ff @(posedge clk) begin
        if (regs.rd0_en) begin
            regs.rd0_data <= mem[regs.rd0_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (regs.rd1_en) begin
            regs.rd1_data <= mem[regs.rd1_addr];
        end
    end

    // ********************************************************************
    // checks
    // ********************************************************************

    // one write-back per instruction, so writes never come back to back.
    a_single_write: assert property (
        @(posedge clk) disable iff (reset)
        regs.wr_en |=> !regs.wr_en
    ) else $error("register_file: wr_en high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== rtl/op_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  regalu_pkg::op_t       opcode,
    input  regalu_pkg::reg_addr_t dest,
    input  regalu_pkg::reg_addr_t src_a,
    input  regalu_pkg::reg_addr_t src_b,
    input  regalu_pkg::data_t     imm,
    output logic                  ack,
    output regalu_pkg::data_t     result,
    output logic                  carry,
    regfile_if.seq                rf,
    input  regalu_pkg::data_t     sum,
    input  logic                  cout,
    output logic                  subtract
);

    regalu_pkg::seq_state_t state;
    regalu_pkg::seq_state_t state_next;

    regalu_pkg::op_t        op_q;
    regalu_pkg::reg_addr_t  dest_q;
    regalu_pkg::reg_addr_t  src_a_q;
    regalu_pkg::reg_addr_t  src_b_q;
    regalu_pkg::data_t      imm_q;

    logic accept;

    assign accept = (state == regalu_pkg::st_idle) && req;

    // ********************************************************************
    // state machine
    // ********************************************************************

    always_comb begin
        state_next = state;
        unique case (state)
            regalu_pkg::st_idle: begin
                if (req) begin
                    state_next = regalu_pkg::st_read;
                end
            end
            regalu_pkg::st_read: state_next = regalu_pkg::st_exec;
            regalu_pkg::st_exec: state_next = regalu_pkg::st_ack;
            regalu_pkg::st_ack: begin
                if (!req) begin
                    state_next = regalu_pkg::st_idle;  // host has seen ack.
                end
            end
            default: state_next = regalu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= regalu_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // instruction is captured once and held for the whole sequence.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= opcode;
            dest_q  <= dest;
            src_a_q <= src_a;
            src_b_q <= src_b;
            imm_q   <= imm;
        end
    end

    // ********************************************************************
    // register file and alu control
    // ********************************************************************

    assign rf.rd0_en   = (state == regalu_pkg::st_read);
    assign rf.rd0_addr = src_a_q;
    assign rf.rd1_en   = (state == regalu_pkg::st_read);
    assign rf.rd1_addr = src_b_q;

    assign subtract    = (op_q == regalu_pkg::op_sub);

    assign rf.wr_en    = (state == regalu_pkg::st_exec) && (op_q != regalu_pkg::op_read);
    assign rf.wr_addr  = dest_q;
    assign rf.wr_data  = (op_q == regalu_pkg::op_load) ? imm_q : sum;

    assign ack = (state == regalu_pkg::st_ack);

    // ********************************************************************
    // result and carry
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            carry  <= 1'b0;
        end else if (state == regalu_pkg::st_exec) begin
            unique case (op_q)
                regalu_pkg::op_load: begin
                    result <= imm_q;
                    carry  <= 1'b0;
                end
                regalu_pkg::op_read: begin
                    result <= rf.rd0_data;
                    carry  <= 1'b0;
                end
                default: begin     // add and sub.
                    result <= sum;
                    carry  <= cout;
                end
            endcase
        end
    end

    // ********************************************************************
    // handshake checks
    // ********************************************************************

    a_ack_after_req_low: assert property (
        @(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req)
    ) else $error("op_sequencer: ack dropped while req was still high");

    // host must hold the instruction until it sees ack.
    a_inputs_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req && !ack && $past(req && !ack)) |-> $stable({opcode, dest, src_a, src_b, imm})
    ) else $error("op_sequencer: host changed the instruction before ack");

endmodule

`default_nettype wire

// ==== rtl/regalu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module regalu_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  regalu_pkg::op_t       opcode,
    input  regalu_pkg::reg_addr_t dest,
    input  regalu_pkg::reg_addr_t src_a,
    input  regalu_pkg::reg_addr_t src_b,
    input  regalu_pkg::data_t     imm,
    output logic                  ack,
    output regalu_pkg::data_t     result,
    output logic                  carry
);

    regalu_pkg::data_t alu_sum;
    logic              alu_cout;
    logic              alu_subtract;

    regfile_if rf_bus ();

    // ********************************************************************
    // sequencer
    // ********************************************************************

    op_sequencer i_seq (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .opcode   (opcode),
        .dest     (dest),
        .src_a    (src_a),
        .src_b    (src_b),
        .imm      (imm),
        .ack      (ack),
        .result   (result),
        .carry    (carry),
        .rf       (rf_bus.seq),
        .sum      (alu_sum),
        .cout     (alu_cout),
        .subtract (alu_subtract)
    );

    // ********************************************************************
    // datapath
    // ********************************************************************

    register_file i_regs (
        .clk   (clk),
        .reset (reset),
        .regs  (rf_bus.regs)
    );

    // operands come straight off the registered read ports.
    alu i_alu (
        .a        (rf_bus.rd0_data),
        .b        (rf_bus.rd1_data),
        .subtract (alu_subtract),
        .sum      (alu_sum),
        .cout     (alu_cout)
    );

endmodule

`default_nettype wire

// ==== verif/tb_regalu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regalu_defs.svh"

module tb_regalu;

    logic                  clk;
    logic                  reset;
    logic                  req;
    regalu_pkg::op_t       opcode;
    regalu_pkg::reg_addr_t dest;
    regalu_pkg::reg_addr_t src_a;
    regalu_pkg::reg_addr_t src_b;
    regalu_pkg::data_t     imm;
    logic                  ack;
    regalu_pkg::data_t     result;
    logic                  carry;

    regalu_pkg::data_t shadow [`REGALU_REG_COUNT];  // expected register contents.
    logic [7:0]        lfsr_state;
    logic              timed_out;
    int                error_count;
    int                test_count;
    int                failed_tests;
    int                errors_at_start;

    regalu_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .opcode (opcode),
        .dest   (dest),
        .src_a  (src_a),
        .src_b  (src_b),
        .imm    (imm),
        .ack    (ack),
        .result (result),
        .carry  (carry)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ********************************************************************
    // random numbers
    // ********************************************************************

    // maximal length polynomial x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] next_lfsr(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[6:0], lfsr_state[0]};  // one step per bit.
        end
        return v;
    endfunction

    // ********************************************************************
    // reference model and checks
    // ********************************************************************

    task automatic model_op(input regalu_pkg::op_t op, input regalu_pkg::reg_addr_t d,
                            input regalu_pkg::reg_addr_t a, input regalu_pkg::reg_addr_t b,
                            input regalu_pkg::data_t im, output regalu_pkg::data_t er,
                            output logic ec);
        logic [8:0] wide;
        case (op)
            regalu_pkg::op_load: begin
                er = im;
                ec = 1'b0;
                shadow[d] = im;
            end
            regalu_pkg::op_add: begin
                wide = {1'b0, shadow[a]} + {1'b0, shadow[b]};
                er = wide[7:0];
                ec = wide[8];
                shadow[d] = er;
            end
            regalu_pkg::op_sub: begin
                er = shadow[a] - shadow[b];     // wraps modulo 256.
                ec = (shadow[a] >= shadow[b]);  // high when no borrow.
                shadow[d] = er;
            end
            default: begin
                er = shadow[a];
                ec = 1'b0;
            end
        endcase
    endtask

    task automatic check_data(input string name, input regalu_pkg::data_t exp_val,
                              input regalu_pkg::data_t act_val);
        if (act_val !== exp_val) begin
            $display("error %s: expected %h, actual %h", name, exp_val, act_val);
            error_count++;
        end
    endtask

    task automatic check_carry(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("error %s: expected carry %b, actual carry %b", name, exp_val, act_val);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // ********************************************************************
    // host side of the handshake
    // ********************************************************************

    // called and returns 5 ns after a rising edge.
    task automatic run_op(input string name, input regalu_pkg::op_t op,
                          input regalu_pkg::reg_addr_t d, input regalu_pkg::reg_addr_t a,
                          input regalu_pkg::reg_addr_t b, input regalu_pkg::data_t im,
                          input int hold, output regalu_pkg::data_t res, output logic cy);
        int   cycles;
        logic seen;
        req    = 1'b1;
        opcode = op;
        dest   = d;
        src_a  = a;
        src_b  = b;
        imm    = im;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 20) begin
            @(posedge clk);
            #5;
            cycles++;
            seen = ack;
        end
        if (!seen) begin
            $display("%s: ack did not rise within 20 cycles of req", name);
            error_count++;
            timed_out = 1'b1;
        end else begin
            if (cycles != 3) begin
                $display("error %s: expected ack after 3 cycles, actual %0d", name, cycles);
                error_count++;
            end
            res = result;
            cy  = carry;
            for (int k = 0; k < hold; k++) begin
                @(posedge clk);
                #5;
                if (!ack) begin
                    $display("%s: ack dropped while req was still high", name);
                    error_count++;
                end
            end
            req    = 1'b0;
            cycles = 0;
            while (ack && cycles < 20) begin
                @(posedge clk);
                #5;
                cycles++;
            end
            if (ack) begin
                $display("%s: ack stayed high 20 cycles after req fell", name);
                error_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic do_op(input string name, input regalu_pkg::op_t op,
                         input regalu_pkg::reg_addr_t d, input regalu_pkg::reg_addr_t a,
                         input regalu_pkg::reg_addr_t b, input regalu_pkg::data_t im,
                         input int hold);
        regalu_pkg::data_t exp_res;
        regalu_pkg::data_t got_res;
        logic              exp_cy;
        logic              got_cy;
        if (!timed_out) begin
            model_op(op, d, a, b, im, exp_res, exp_cy);
            run_op(name, op, d, a, b, im, hold, got_res, got_cy);
            if (!timed_out) begin
                check_data(name, exp_res, got_res);
                check_carry(name, exp_cy, got_cy);
            end
        end
    endtask

    task automatic read_reg(input string name, input int r);
        do_op(name, regalu_pkg::op_read, '0, regalu_pkg::reg_addr_t'(r), '0, '0, 0);
    endtask

    task automatic start_test();
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_at_start);
            failed_tests++;
        end
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************

    task automatic test_reset_state();
        start_test();
        if (ack !== 1'b0) begin
            $display("error reset_state: expected ack 0, actual ack %b", ack);
            error_count++;
        end
        check_data("reset_state", '0, result);
        check_carry("reset_state", 1'b0, carry);
        for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
            read_reg("reset_state", i);
        end
        end_test("reset_state");
    endtask

    task automatic test_load_all();
        start_test();
        for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
            do_op("load_all", regalu_pkg::op_load, regalu_pkg::reg_addr_t'(i), '0, '0,
                  regalu_pkg::data_t'(i * 17), 0);
        end
        for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
            read_reg("load_all", i);
        end
        end_test("load_all");
    endtask

    task automatic test_add();
        start_test();
        do_op("add", regalu_pkg::op_add, 3'd4, 3'd2, 3'd3, '0, 0);
        read_reg("add", 4);
        do_op("add_overflow", regalu_pkg::op_load, 3'd5, '0, '0, 8'd200, 0);
        do_op("add_overflow", regalu_pkg::op_load, 3'd6, '0, '0, 8'd100, 0);
        do_op("add_overflow", regalu_pkg::op_add, 3'd1, 3'd5, 3'd6, '0, 0);  // 300 wraps.
        read_reg("add_overflow", 1);
        end_test("add");
    endtask

    task automatic test_sub();
        start_test();
        do_op("sub_no_borrow", regalu_pkg::op_sub, 3'd0, 3'd5, 3'd6, '0, 0);
        read_reg("sub_no_borrow", 0);
        do_op("sub_borrow", regalu_pkg::op_sub, 3'd0, 3'd6, 3'd5, '0, 0);
        read_reg("sub_borrow", 0);
        end_test("sub");
    endtask

    task automatic test_dest_is_source();
        start_test();
        do_op("dest_is_source", regalu_pkg::op_add, 3'd2, 3'd2, 3'd7, '0, 3);  // req held.
        read_reg("dest_is_source", 2);
        end_test("dest_is_source");
    endtask

    task automatic test_random();
        regalu_pkg::op_t op;
        logic [7:0]      bits;
        start_test();
        for (int n = 0; n < 40; n++) begin
            bits = take_bits(2);
            op   = regalu_pkg::op_t'(bits[1:0]);
            do_op($sformatf("random_%0d", n), op, regalu_pkg::reg_addr_t'(take_bits(3)),
                  regalu_pkg::reg_addr_t'(take_bits(3)), regalu_pkg::reg_addr_t'(take_bits(3)),
                  take_bits(8), 0);
        end
        for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
            read_reg("random_readback", i);
        end
        end_test("random");
    endtask

    initial begin
        reset        = 1'b1;
        req          = 1'b0;
        opcode       = regalu_pkg::op_load;
        dest         = '0;
        src_a        = '0;
        src_b        = '0;
        imm          = '0;
        lfsr_state   = 8'd71;
        timed_out    = 1'b0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        for (int i = 0; i < `REGALU_REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        test_reset_state();
        test_load_all();
        test_add();
        test_sub();
        test_dest_is_source();
        test_random();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
rtl/regalu_pkg.sv
rtl/regfile_if.sv
rtl/alu.sv
rtl/register_file.sv
rtl/op_sequencer.sv
rtl/regalu_top.sv
verif/tb_regalu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the regalu testbench with verilator.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_regalu -f list.f -o sim_regalu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_regalu)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the run passes only when the testbench printed its pass line.
if printf '%s\n' "$sim_out" | grep -qx "PASS: all tests"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
